// ==== logic/alu.sv ====
// 8-bit alu, binary add with carry, logic ops, inc/dec
`timescale 1ns/10ps

module alu import aluPkg::*; (
  input  aluOp_t     aluOp,
  input  logic [7:0] a,
  input  logic [7:0] b,
  input  logic       carryIn,
  output logic [7:0] result,
  output logic       carryOut,
  output logic       overflow
);

  // ninth bit holds the carry out
  logic [8:0] sum;

  always_comb begin
    sum      = {1'b0, a} + {1'b0, b} + {8'h00, carryIn};
    result   = b;
    carryOut = 1'b0;
    overflow = 1'b0;
    case (aluOp)
      AluAdc: begin
        result   = sum[7:0];
        carryOut = sum[8];
        // same-sign inputs, result sign flipped
        overflow = (a[7] == b[7]) && (sum[7] != a[7]);
      end
      AluAnd: result = a & b;
      AluOra: result = a | b;
      AluEor: result = a ^ b;
      // index counting wraps, no carry involved
      AluInc: result = b + 8'd1;
      AluDec: result = b - 8'd1;
      AluPass: result = b;
      default: result = b;
    endcase
  end

endmodule

// ==== logic/aluPkg.sv ====
// datapath types
// alu operation select and register select
package aluPkg;

  // alu function, pass/inc/dec work on the b operand
  typedef enum logic [2:0] {
    AluPass,
    AluAdc,
    AluAnd,
    AluOra,
    AluEor,
    AluInc,
    AluDec
  } aluOp_t;

  // operand source and write-back target
  // RegNone means no register involved
  typedef enum logic [1:0] {
    RegA,
    RegX,
    RegY,
    RegNone
  } regSel_t;

endpackage

// ==== logic/cpu6502Top.sv ====
// cpu top, control and datapath wiring, external bus
`timescale 1ns/10ps

module cpu6502Top import cpuPkg::*, aluPkg::*; (
  input  logic        phi0,
  input  logic        arstN,
  input  logic [7:0]  dataIn,
  output logic [15:0] addr,
  output logic [7:0]  dataOut,
  output logic        rw,
  output logic        sync
);

  // fsm strobes
  logic        pcInc;
  logic        pcBranch;
  logic        addrFromPc;
  logic        loadOpcode;
  logic        loadOperand;
  logic        commit;
  logic        memWrite;
  // decoded control word
  instrClass_t instrClass;
  aluOp_t      aluOp;
  regSel_t     srcReg;
  regSel_t     dstReg;
  logic        useOperand;
  logic        setNz;
  logic        setCv;
  logic        setC;
  logic        clrC;
  logic [1:0]  condSel;
  logic        condSense;
  // datapath
  logic [15:0] pc;
  logic [7:0]  opcodeReg;
  logic [7:0]  operandReg;
  logic [7:0]  srcData;
  logic [7:0]  accData;
  logic [7:0]  aluB;
  logic [7:0]  aluResult;
  logic        aluCarry;
  logic        aluOverflow;
  logic        carry;
  logic        branchTaken;

  // instruction register, starts out as a nop
  always_ff @(posedge phi0 or negedge arstN) begin
    if (!arstN) opcodeReg <= OpNop;
    else if (loadOpcode) opcodeReg <= dataIn;
  end

  // zero page address or branch offset, read in T1
  always_ff @(posedge phi0) begin
    if (loadOperand) operandReg <= dataIn;
  end

  timingFsm uFsm (
    .phi0(phi0), .arstN(arstN), .instrClass(instrClass), .branchTaken(branchTaken),
    .sync(sync), .pcInc(pcInc), .pcBranch(pcBranch), .addrFromPc(addrFromPc),
    .loadOpcode(loadOpcode), .loadOperand(loadOperand), .commit(commit),
    .memWrite(memWrite)
  );

  programCounter uPc (
    .phi0(phi0), .arstN(arstN), .pcInc(pcInc), .pcBranch(pcBranch),
    .offset(operandReg), .pc(pc)
  );

  instrDecode uDecode (
    .opcode(opcodeReg), .instrClass(instrClass), .aluOp(aluOp),
    .srcReg(srcReg), .dstReg(dstReg), .useOperand(useOperand),
    .setNz(setNz), .setCv(setCv), .setC(setC), .clrC(clrC),
    .condSel(condSel), .condSense(condSense)
  );

  // immediates come off the bus in the same T1 cycle they commit
  assign aluB = useOperand ? dataIn : srcData;

  alu uAlu (
    .aluOp(aluOp), .a(accData), .b(aluB), .carryIn(carry),
    .result(aluResult), .carryOut(aluCarry), .overflow(aluOverflow)
  );

  registerFile uRegs (
    .phi0(phi0), .arstN(arstN), .commit(commit), .dstReg(dstReg), .srcReg(srcReg),
    .wrData(aluResult), .srcData(srcData), .accData(accData)
  );

  statusReg uStatus (
    .phi0(phi0), .arstN(arstN), .commit(commit), .setNz(setNz), .setCv(setCv),
    .setC(setC), .clrC(clrC), .result(aluResult), .carryOut(aluCarry),
    .overflow(aluOverflow), .condSel(condSel), .condSense(condSense),
    .carry(carry), .branchTaken(branchTaken)
  );

  // external bus
  assign addr    = addrFromPc ? pc : {8'h00, operandReg};
  assign rw      = !memWrite;
  // store source register, only sampled when rw is low
  assign dataOut = srcData;

endmodule

// ==== logic/cpuPkg.sv ====
// 6502 subset instruction-set constants
// opcodes, start address, flag bit positions, instruction classes
package cpuPkg;

  // immediate loads
  localparam logic [7:0] OpLdaImm = 8'hA9;
  localparam logic [7:0] OpLdxImm = 8'hA2;
  localparam logic [7:0] OpLdyImm = 8'hA0;
  // immediate alu ops, binary mode only
  localparam logic [7:0] OpAdcImm = 8'h69;
  localparam logic [7:0] OpAndImm = 8'h29;
  localparam logic [7:0] OpOraImm = 8'h09;
  localparam logic [7:0] OpEorImm = 8'h49;
  // zero page stores
  localparam logic [7:0] OpStaZp = 8'h85;
  localparam logic [7:0] OpStxZp = 8'h86;
  localparam logic [7:0] OpStyZp = 8'h84;
  // register transfers
  localparam logic [7:0] OpTax = 8'hAA;
  localparam logic [7:0] OpTay = 8'hA8;
  localparam logic [7:0] OpTxa = 8'h8A;
  localparam logic [7:0] OpTya = 8'h98;
  // index counting
  localparam logic [7:0] OpInx = 8'hE8;
  localparam logic [7:0] OpIny = 8'hC8;
  localparam logic [7:0] OpDex = 8'hCA;
  localparam logic [7:0] OpDey = 8'h88;
  // flag ops and nop
  localparam logic [7:0] OpClc = 8'h18;
  localparam logic [7:0] OpSec = 8'h38;
  localparam logic [7:0] OpNop = 8'hEA;
  // relative branches, bits 7:6 pick the flag, bit 5 the sense
  localparam logic [7:0] OpBpl = 8'h10;
  localparam logic [7:0] OpBmi = 8'h30;
  localparam logic [7:0] OpBvc = 8'h50;
  localparam logic [7:0] OpBvs = 8'h70;
  localparam logic [7:0] OpBcc = 8'h90;
  localparam logic [7:0] OpBcs = 8'hB0;
  localparam logic [7:0] OpBne = 8'hD0;
  localparam logic [7:0] OpBeq = 8'hF0;

  // first fetch address after reset
  localparam logic [15:0] ResetAddr = 16'h0200;

  // index into the 4-bit flags word
  localparam logic [1:0] StatusN = 2'd3;
  localparam logic [1:0] StatusV = 2'd2;
  localparam logic [1:0] StatusZ = 2'd1;
  localparam logic [1:0] StatusC = 2'd0;

  // picks the T-state path through the FSM
  typedef enum logic [2:0] {ClsImm, ClsImplied, ClsStoreZp, ClsBranch, ClsIllegal} instrClass_t;

endpackage

// ==== logic/instrDecode.sv ====
// opcode decoder, produces the datapath control word
`timescale 1ns/10ps

module instrDecode import cpuPkg::*, aluPkg::*; (
  input  logic [7:0]  opcode,
  output instrClass_t instrClass,
  output aluOp_t      aluOp,
  output regSel_t     srcReg,
  output regSel_t     dstReg,
  output logic        useOperand,
  output logic        setNz,
  output logic        setCv,
  output logic        setC,
  output logic        clrC,
  output logic [1:0]  condSel,
  output logic        condSense
);

  // branch test fields come straight from the opcode bits
  always_comb begin
    case (opcode[7:6])
      2'b00:   condSel = StatusN;
      2'b01:   condSel = StatusV;
      2'b10:   condSel = StatusC;
      default: condSel = StatusZ;
    endcase
    condSense = opcode[5];
  end

  // class and flag updates
  always_comb begin
    instrClass = ClsIllegal;
    useOperand = 1'b0;
    setNz      = 1'b0;
    setCv      = 1'b0;
    setC       = 1'b0;
    clrC       = 1'b0;
    case (opcode)
      OpLdaImm, OpLdxImm, OpLdyImm, OpAdcImm, OpAndImm, OpOraImm, OpEorImm: begin
        instrClass = ClsImm;
        useOperand = 1'b1;
        setNz      = 1'b1;
        setCv      = (opcode == OpAdcImm);
      end
      OpStaZp, OpStxZp, OpStyZp: instrClass = ClsStoreZp;
      OpTax, OpTay, OpTxa, OpTya, OpInx, OpIny, OpDex, OpDey: begin
        instrClass = ClsImplied;
        setNz      = 1'b1;
      end
      OpClc, OpSec, OpNop: begin
        instrClass = ClsImplied;
        setC       = (opcode == OpSec);
        clrC       = (opcode == OpClc);
      end
      OpBpl, OpBmi, OpBvc, OpBvs, OpBcc, OpBcs, OpBne, OpBeq: instrClass = ClsBranch;
      // illegal opcodes fall through as a nop
      default: instrClass = ClsIllegal;
    endcase
  end

  // write-back target
  always_comb begin
    case (opcode)
      OpLdaImm, OpAdcImm, OpAndImm, OpOraImm, OpEorImm, OpTxa, OpTya: dstReg = RegA;
      OpLdxImm, OpTax, OpInx, OpDex: dstReg = RegX;
      OpLdyImm, OpTay, OpIny, OpDey: dstReg = RegY;
      default: dstReg = RegNone;
    endcase
  end

  // operand source, also the store data
  always_comb begin
    case (opcode)
      OpStaZp, OpTax, OpTay: srcReg = RegA;
      OpStxZp, OpTxa, OpInx, OpDex: srcReg = RegX;
      OpStyZp, OpTya, OpIny, OpDey: srcReg = RegY;
      default: srcReg = RegNone;
    endcase
  end

  // alu function, loads and transfers just pass b
  always_comb begin
    case (opcode)
      OpAdcImm: aluOp = AluAdc;
      OpAndImm: aluOp = AluAnd;
      OpOraImm: aluOp = AluOra;
      OpEorImm: aluOp = AluEor;
      OpInx, OpIny: aluOp = AluInc;
      OpDex, OpDey: aluOp = AluDec;
      default: aluOp = AluPass;
    endcase
  end

endmodule

// ==== logic/programCounter.sv ====
// program counter, increment and relative branch add
`timescale 1ns/10ps

module programCounter import cpuPkg::*; (
  input  logic        phi0,
  input  logic        arstN,
  input  logic        pcInc,
  input  logic        pcBranch,
  input  logic [7:0]  offset,
  output logic [15:0] pc
);

  logic [15:0] offsetExt;

  // branch offset is signed, extend to full width
  assign offsetExt = {{8{offset[7]}}, offset};

  always_ff @(posedge phi0 or negedge arstN) begin
    if (!arstN) begin
      pc <= ResetAddr;
    end else if (pcBranch) begin
      // carry runs into the high byte, no page fixup cycle
      pc <= pc + offsetExt;
    end else if (pcInc) begin
      pc <= pc + 16'd1;
    end
  end

endmodule

// ==== logic/registerFile.sv ====
// A, X and Y registers with write-back and source select
`timescale 1ns/10ps

module registerFile import aluPkg::*; (
  input  logic       phi0,
  input  logic       arstN,
  input  logic       commit,
  input  regSel_t    dstReg,
  input  regSel_t    srcReg,
  input  logic [7:0] wrData,
  output logic [7:0] srcData,
  output logic [7:0] accData
);

  logic [7:0] aReg;
  logic [7:0] xReg;
  logic [7:0] yReg;

  always_ff @(posedge phi0 or negedge arstN) begin
    if (!arstN) begin
      aReg <= 8'h00;
      xReg <= 8'h00;
      yReg <= 8'h00;
    end else if (commit) begin
      // RegNone leaves all three alone
      case (dstReg)
        RegA: aReg <= wrData;
        RegX: xReg <= wrData;
        RegY: yReg <= wrData;
        default: ;
      endcase
    end
  end

  // feeds alu b and the store data path
  always_comb begin
    case (srcReg)
      RegA:    srcData = aReg;
      RegX:    srcData = xReg;
      RegY:    srcData = yReg;
      default: srcData = 8'h00;
    endcase
  end

  // accumulator for two-operand ops
  assign accData = aReg;

endmodule

// ==== logic/statusReg.sv ====
// N, V, Z, C flags and the branch condition test
`timescale 1ns/10ps

module statusReg import cpuPkg::*; (
  input  logic       phi0,
  input  logic       arstN,
  input  logic       commit,
  input  logic       setNz,
  input  logic       setCv,
  input  logic       setC,
  input  logic       clrC,
  input  logic [7:0] result,
  input  logic       carryOut,
  input  logic       overflow,
  input  logic [1:0] condSel,
  input  logic       condSense,
  output logic       carry,
  output logic       branchTaken
);

  logic [3:0] flags;

  always_ff @(posedge phi0 or negedge arstN) begin
    if (!arstN) begin
      flags <= 4'h0;
    end else if (commit) begin
      if (setNz) begin
        flags[StatusN] <= result[7];
        flags[StatusZ] <= (result == 8'h00);
      end
      // adc only
      if (setCv) begin
        flags[StatusC] <= carryOut;
        flags[StatusV] <= overflow;
      end
      // sec / clc
      if (setC) flags[StatusC] <= 1'b1;
      else if (clrC) flags[StatusC] <= 1'b0;
    end
  end

  assign carry = flags[StatusC];
  // condSel is already a flag index
  assign branchTaken = (flags[condSel] == condSense);

endmodule

// ==== logic/timingFsm.sv ====
// timing state machine, steps T0/T1/T2 and issues per-cycle strobes
`timescale 1ns/10ps

module timingFsm import cpuPkg::*; (
  input  logic        phi0,
  input  logic        arstN,
  input  instrClass_t instrClass,
  input  logic        branchTaken,
  output logic        sync,
  output logic        pcInc,
  output logic        pcBranch,
  output logic        addrFromPc,
  output logic        loadOpcode,
  output logic        loadOperand,
  output logic        commit,
  output logic        memWrite
);

  typedef enum logic [1:0] {T0, T1, T2} tState_t;

  tState_t state;
  tState_t stateNext;
  // low during reset, keeps the first fetch from starting early
  logic    running;
  logic    fetch;

  always_ff @(posedge phi0 or negedge arstN) begin
    if (!arstN) begin
      state   <= T0;
      running <= 1'b0;
    end else begin
      state   <= stateNext;
      running <= 1'b1;
    end
  end

  // opcode fetch cycle
  assign fetch = running && (state == T0);

  always_comb begin
    stateNext = state;
    case (state)
      T0: begin
        if (running) stateNext = T1;
      end
      T1: begin
        // stores and taken branches need the extra cycle
        if (instrClass == ClsStoreZp) stateNext = T2;
        else if (instrClass == ClsBranch && branchTaken) stateNext = T2;
        else stateNext = T0;
      end
      default: stateNext = T0;
    endcase
  end

  assign sync        = fetch;
  assign loadOpcode  = fetch;
  // implied ops and illegals leave the pc on the next opcode
  assign pcInc       = fetch || (state == T1 && instrClass != ClsImplied
                                 && instrClass != ClsIllegal);
  // operand latched in every T1, used by stores and branches
  assign loadOperand = (state == T1);
  assign commit      = (state == T1) && (instrClass == ClsImm || instrClass == ClsImplied);
  assign memWrite    = (state == T2) && (instrClass == ClsStoreZp);
  assign pcBranch    = (state == T2) && (instrClass == ClsBranch);
  // only the store write cycle addresses zero page
  assign addrFromPc  = !memWrite;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the cpu testbench under Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tbCpu -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/VtbCpu)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qxF ">>> PASS"; then
  exit 0
fi
exit 1

// ==== tests/tbProgram.svh ====
// program image and expected bus writes for the cpu testbench
// included inside the testbench module
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// pc: fetch address of the store opcode
// gap: cycles from the previous sync to the store's sync
// zp: zero page address written, data: byte written
typedef struct packed {
  logic [15:0] pc;
  logic [3:0]  gap;
  logic [7:0]  zp;
  logic [7:0]  data;
} writeEntry_t;

localparam int ProgLen   = 154;
localparam int NumWrites = 32;

// loaded at ResetAddr onwards
localparam logic [7:0] ProgBytes [ProgLen] = '{
  // 0200 loads and zero page stores
  8'hA9, 8'h5A, 8'h85, 8'h10, 8'hA2, 8'hC3, 8'h86, 8'h11, 8'hA0, 8'h07, 8'h84, 8'h12,
  // 020C sec, lda, adc, sta / clc, adc, sta, adc, sta
  8'h38, 8'hA9, 8'h7F, 8'h69, 8'h00, 8'h85, 8'h13,
  8'h18, 8'h69, 8'h90, 8'h85, 8'h14, 8'h69, 8'h05, 8'h85, 8'h15,
  // 021C and, ora, eor, sta
  8'h29, 8'hF3, 8'h09, 8'h0C, 8'h49, 8'hFF, 8'h85, 8'h16,
  // 0224 tax, stx, tay, iny, sty
  8'hAA, 8'h86, 8'h17, 8'hA8, 8'hC8, 8'h84, 8'h18,
  // 022B ldx #FE, inx twice across the wrap, txa, sta
  8'hA2, 8'hFE, 8'hE8, 8'hE8, 8'h8A, 8'h85, 8'h19,
  // 0232 dex below zero, stx, ldy #0, dey, tya, sta
  8'hCA, 8'h86, 8'h1A, 8'hA0, 8'h00, 8'h88, 8'h98, 8'h85, 8'h1B,
  // 023B branch pairs with N1 Z0 C0 V0, not taken then taken
  8'h10, 8'h02, 8'h86, 8'h20, 8'h30, 8'h02, 8'h86, 8'h3F, 8'h84, 8'h21,
  8'hF0, 8'h02, 8'h86, 8'h22, 8'hD0, 8'h02, 8'h86, 8'h3F, 8'h84, 8'h23,
  8'hB0, 8'h02, 8'h86, 8'h24, 8'h90, 8'h02, 8'h86, 8'h3F, 8'h84, 8'h25,
  8'h70, 8'h02, 8'h86, 8'h26, 8'h50, 8'h02, 8'h86, 8'h3F, 8'h84, 8'h27,
  // 0263 80 + 80 gives 00 with N0 Z1 C1 V1
  8'hA9, 8'h80, 8'h69, 8'h80,
  // 0267 branch pairs with the flipped flags
  8'h30, 8'h02, 8'h86, 8'h28, 8'h10, 8'h02, 8'h86, 8'h3F, 8'h84, 8'h29,
  8'hD0, 8'h02, 8'h86, 8'h2A, 8'hF0, 8'h02, 8'h86, 8'h3F, 8'h84, 8'h2B,
  8'h90, 8'h02, 8'h86, 8'h2C, 8'hB0, 8'h02, 8'h86, 8'h3F, 8'h84, 8'h2D,
  8'h50, 8'h02, 8'h86, 8'h2E, 8'h70, 8'h02, 8'h86, 8'h3F, 8'h84, 8'h2F,
  // 028F countdown loop, bne back by 5
  8'hA2, 8'h03, 8'h86, 8'h30, 8'hCA, 8'hD0, 8'hFB,
  // 0296 nop, illegal 02, final store
  8'hEA, 8'h02, 8'h86, 8'h31
};

// zp 3F is the skipped store, never written
localparam writeEntry_t ExpWrites [NumWrites] = '{
  {16'h0202, 4'd2, 8'h10, 8'h5A},
  {16'h0206, 4'd2, 8'h11, 8'hC3},
  {16'h020A, 4'd2, 8'h12, 8'h07},
  // adc with carry in set, then clear, then carry out fed back
  {16'h0211, 4'd2, 8'h13, 8'h7F + 8'h00 + 8'h01},
  {16'h0216, 4'd2, 8'h14, 8'h80 + 8'h90},
  {16'h021A, 4'd2, 8'h15, 8'h10 + 8'h05 + 8'h01},
  {16'h0222, 4'd2, 8'h16, ((8'h16 & 8'hF3) | 8'h0C) ^ 8'hFF},
  // transfers and counting
  {16'h0225, 4'd2, 8'h17, 8'hE1},
  {16'h0229, 4'd2, 8'h18, 8'hE1 + 8'h01},
  {16'h0230, 4'd2, 8'h19, 8'hFE + 8'h01 + 8'h01},
  {16'h0233, 4'd2, 8'h1A, 8'h00 - 8'h01},
  {16'h0239, 4'd2, 8'h1B, 8'h00 - 8'h01},
  // not taken store has gap 2, store after a taken branch gap 3
  {16'h023D, 4'd2, 8'h20, 8'hFF},
  {16'h0243, 4'd3, 8'h21, 8'hFF},
  {16'h0247, 4'd2, 8'h22, 8'hFF},
  {16'h024D, 4'd3, 8'h23, 8'hFF},
  {16'h0251, 4'd2, 8'h24, 8'hFF},
  {16'h0257, 4'd3, 8'h25, 8'hFF},
  {16'h025B, 4'd2, 8'h26, 8'hFF},
  {16'h0261, 4'd3, 8'h27, 8'hFF},
  {16'h0269, 4'd2, 8'h28, 8'hFF},
  {16'h026F, 4'd3, 8'h29, 8'hFF},
  {16'h0273, 4'd2, 8'h2A, 8'hFF},
  {16'h0279, 4'd3, 8'h2B, 8'hFF},
  {16'h027D, 4'd2, 8'h2C, 8'hFF},
  {16'h0283, 4'd3, 8'h2D, 8'hFF},
  {16'h0287, 4'd2, 8'h2E, 8'hFF},
  {16'h028D, 4'd3, 8'h2F, 8'hFF},
  // loop body refetched at 0291 after each taken bne
  {16'h0291, 4'd2, 8'h30, 8'h03},
  {16'h0291, 4'd3, 8'h30, 8'h02},
  {16'h0291, 4'd3, 8'h30, 8'h01},
  {16'h0298, 4'd2, 8'h31, 8'h00}
};

`endif

// ==== tests/tbCpu.sv ====
// testbench for the 6502 subset cpu
// memory model, program run and bus write checks
`timescale 1ns/10ps

module tbCpu import cpuPkg::*; ();

  // program image and expected writes
  `include "tbProgram.svh"

  // four cycles per program byte leaves margin over the slowest path
  localparam int CycleLimit = 4 * ProgLen + 20;

  logic        phi0;
  logic        arstN;
  logic [7:0]  dataIn;
  logic [15:0] addr;
  logic [7:0]  dataOut;
  logic        rw;
  logic        sync;

  logic [7:0]  mem [65536];
  int          errorCount;
  int          cycle;
  int          writeIdx;
  int          syncCycle;
  int          prevSyncCycle;
  logic [15:0] syncAddr;
  writeEntry_t expWrite;

  cpu6502Top uut (
    .phi0(phi0), .arstN(arstN), .dataIn(dataIn), .addr(addr),
    .dataOut(dataOut), .rw(rw), .sync(sync)
  );

  // 8 ns clock
  initial begin
    phi0 = 1'b0;
    forever #4 phi0 = ~phi0;
  end

  // read data in the same cycle
  assign dataIn = mem[addr];

  // memory takes the byte at the rising edge that ends the write cycle
  always @(posedge phi0) begin
    if (!rw) mem[addr] <= dataOut;
  end

  task automatic checkValue(input string name, input logic [15:0] got,
                            input logic [15:0] expected);
    if (got !== expected) begin
      $display("error %s got %h expected %h at cycle %0d", name, got, expected, cycle);
      errorCount++;
    end
  endtask

  task automatic loadMemory();
    for (int i = 0; i < 65536; i++) begin
      // fill mixes both address bytes
      mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;
    end
    for (int i = 0; i < ProgLen; i++) begin
      mem[int'(ResetAddr) + i] = ProgBytes[i];
    end
  endtask

  // one observed write against the next table entry
  task automatic checkStore();
    expWrite = ExpWrites[writeIdx];
    checkValue("addr", addr, {8'h00, expWrite.zp});
    checkValue("dataOut", {8'h00, dataOut}, {8'h00, expWrite.data});
    // store opcode fetched two cycles before the write
    checkValue("sync addr", syncAddr, expWrite.pc);
    checkValue("store cycles", 16'(cycle - syncCycle), 16'h0002);
    // length of whatever ran before the store
    checkValue("sync gap", 16'(syncCycle - prevSyncCycle), {12'h000, expWrite.gap});
    writeIdx++;
  endtask

  initial begin
    arstN         = 1'b0;
    errorCount    = 0;
    cycle         = 0;
    writeIdx      = 0;
    syncCycle     = 0;
    prevSyncCycle = 0;
    syncAddr      = 16'h0000;
    loadMemory();
    // bus idle through reset
    repeat (8) begin
      @(negedge phi0);
      checkValue("rw", {15'h0000, rw}, 16'h0001);
      checkValue("sync", {15'h0000, sync}, 16'h0000);
    end
    @(posedge phi0);
    arstN <= 1'b1;
    // first edge that sees reset released
    @(posedge phi0);
    @(negedge phi0);
    checkValue("sync", {15'h0000, sync}, 16'h0001);
    checkValue("addr", addr, ResetAddr);
    // sample mid-cycle where the bus is stable
    while (writeIdx < NumWrites && cycle < CycleLimit) begin
      if (sync) begin
        prevSyncCycle = syncCycle;
        syncCycle     = cycle;
        syncAddr      = addr;
      end
      if (!rw) begin
        checkStore();
      end
      @(negedge phi0);
      cycle++;
    end
    if (writeIdx < NumWrites) begin
      $display("run stopped after %0d cycles with only %0d of %0d writes seen",
               cycle, writeIdx, NumWrites);
      errorCount++;
    end
    $display("errors: %0d", errorCount);
    if (errorCount == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+tests
logic/cpuPkg.sv
logic/aluPkg.sv
logic/timingFsm.sv
logic/programCounter.sv
logic/instrDecode.sv
logic/alu.sv
logic/registerFile.sv
logic/statusReg.sv
logic/cpu6502Top.sv
tests/tbCpu.sv
